// File: common/chipbus_params.svh
// chip bus constants for widths, address map, reset stretch and clock rates; include where needed
`ifndef CHIPBUS_PARAMS_SVH
`define CHIPBUS_PARAMS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define DATA_W          16          // chip bus data word
`define CPU_AW          23          // cpu word address, byte address bits [23:1]
`define CHIP_AW         14          // chip ram word address, 32 KB

// ------------------------------
// address map (byte addresses)
// ------------------------------
`define CHIP_SPACE_TOP  24'h200000  // chip ram mirrors below this
`define CUSTOM_BASE     24'hDFF000  // custom register block
`define CUSTOM_WIN_AW   12          // 4 KB window
`define RTC_BASE        24'hDC0000  // rtc nibble window
`define RTC_WIN_AW      16          // 64 KB window

// ------------------------------
// system control
// ------------------------------
`define RESET_FRAMES    4           // sof pulses held after last reset source
`define CLK_HZ          28000000    // system clock
`define SAMPLE_HZ       44100       // audio sample rate

`endif

// File: common/chipbus_pkg.sv
// shared chip bus types, decoder regions and arbiter states; import into the modules that use them
`include "chipbus_params.svh"

package chipbus_pkg;

	// ------------------------------
	// bus vectors
	// ------------------------------
	typedef logic [`DATA_W-1:0]   data_t;     // one bus word
	typedef logic [`CPU_AW-1:0]   cpu_adr_t;  // cpu word address
	typedef logic [`CPU_AW:0]     byte_adr_t; // cpu byte address, bit 0 always low
	typedef logic [`CHIP_AW-1:0]  chip_adr_t; // chip ram word address
	typedef logic [1:0]           bsel_t;     // [1] upper byte, [0] lower byte

	typedef logic [63:0]          rtc_t;      // 16 bcd nibbles from the rtc
	typedef logic [31:0]          acc_t;      // sample clock accumulator

	// ------------------------------
	// decoder and arbiter
	// ------------------------------
	typedef enum logic [1:0] {
		REG_CHIP,   // chip ram, mirrored
		REG_CUSTOM, // custom register block
		REG_RTC,    // rtc nibbles
		REG_NONE    // unmapped, reads zero
	} region_t;

	typedef enum logic [1:0] {
		ARB_IDLE,   // nobody owns chip ram
		ARB_DMA,    // dma granted
		ARB_CPU     // cpu granted
	} arb_state_t;

	// custom register word index
	typedef logic [7:0] reg_idx_t;

	localparam reg_idx_t REG_CFG   = 8'd0; // config, ntsc and user reset
	localparam reg_idx_t REG_FRAME = 8'd1; // frame counter, read only

endpackage

// File: common/wb_if.sv
// Wishbone classic link between blocks inside the design; master and slave views
`timescale 1ns/1ps

interface wb_if;
	import chipbus_pkg::*;

	logic     cyc;   // cycle in progress
	logic     stb;   // strobe, raised with cyc
	logic     we;    // 1 = write
	cpu_adr_t adr;   // word address
	bsel_t    sel;   // byte selects
	data_t    dat_w; // master to slave
	data_t    dat_r; // slave to master, valid with ack
	logic     ack;   // one cycle per transfer

	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, sel, dat_w,
		output dat_r, ack
	);

endinterface

// File: hw/address_decoder.sv
// splits cpu cycles into chip, custom, rtc and unmapped regions and answers the local ones
`timescale 1ns/1ps
`include "chipbus_params.svh"

module address_decoder (
	input logic clk,
	input logic reset,
	wb_if.slave cpu,
	wb_if.master chip,
	wb_if.master regs,
	input chipbus_pkg::rtc_t rtc_i
);
	import chipbus_pkg::*;

	localparam byte_adr_t CHIP_TOP  = `CHIP_SPACE_TOP;
	localparam byte_adr_t CUST_BASE = `CUSTOM_BASE;
	localparam byte_adr_t RTC_LO    = `RTC_BASE;

	byte_adr_t byte_adr;
	region_t   region;
	reg_idx_t  reg_idx;
	logic      req;
	logic      local_req;   // rtc or unmapped
	logic      local_ack_q;
	logic [3:0] nib_idx;
	data_t     local_dat;

	assign byte_adr = {cpu.adr, 1'b0};
	assign req      = cpu.cyc & cpu.stb;
	assign reg_idx  = cpu.adr[$bits(reg_idx_t)-1:0]; // word index in custom window

	// ------------------------------
	// region decode
	// ------------------------------
	always_comb begin
		if (byte_adr < CHIP_TOP)
			region = REG_CHIP;
		else if ((byte_adr >> `CUSTOM_WIN_AW) == (CUST_BASE >> `CUSTOM_WIN_AW))
			region = REG_CUSTOM;
		else if ((byte_adr >> `RTC_WIN_AW) == (RTC_LO >> `RTC_WIN_AW))
			region = REG_RTC;
		else
			region = REG_NONE;
	end

	// chip path, low address bits only so the ram repeats
	assign chip.cyc   = cpu.cyc & (region == REG_CHIP);
	assign chip.stb   = cpu.stb & (region == REG_CHIP);
	assign chip.we    = cpu.we;
	assign chip.adr   = cpu_adr_t'(cpu.adr[`CHIP_AW-1:0]);
	assign chip.sel   = cpu.sel;
	assign chip.dat_w = cpu.dat_w;

	// custom path, register index only
	assign regs.cyc   = cpu.cyc & (region == REG_CUSTOM);
	assign regs.stb   = cpu.stb & (region == REG_CUSTOM);
	assign regs.we    = cpu.we;
	assign regs.adr   = cpu_adr_t'(reg_idx);
	assign regs.sel   = cpu.sel;
	assign regs.dat_w = cpu.dat_w;

	// ------------------------------
	// rtc and unmapped
	// ------------------------------
	assign local_req = req & ((region == REG_RTC) || (region == REG_NONE));

	always_ff @(posedge clk) begin
		if (reset)
			local_ack_q <= 1'b0;
		else
			local_ack_q <= local_req & ~local_ack_q; // one cycle after stb
	end

	assign nib_idx = byte_adr[5:2];

	// writes are dropped, reads outside rtc give zero
	assign local_dat = (region == REG_RTC && !cpu.we) ?
		data_t'(rtc_i[{nib_idx, 2'b00} +: 4]) : '0;

	// return path
	always_comb begin
		case (region)
			REG_CHIP: begin
				cpu.ack   = chip.ack;
				cpu.dat_r = chip.dat_r;
			end
			REG_CUSTOM: begin
				cpu.ack   = regs.ack;
				cpu.dat_r = regs.dat_r;
			end
			default: begin
				cpu.ack   = local_ack_q;
				cpu.dat_r = local_dat;
			end
		endcase
	end

endmodule

// File: hw/chip_arbiter.sv
// shares chip ram between the dma and cpu masters, dma first when both ask from idle
`timescale 1ns/1ps

module chip_arbiter (
	input logic clk,
	input logic reset,
	wb_if.slave dma,
	wb_if.slave cpu,
	wb_if.master ram
);
	import chipbus_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;
	logic       dma_req;
	logic       cpu_req;
	logic       grant;   // someone owns the ram
	logic       sel_cpu; // mux steer

	assign dma_req = dma.cyc & dma.stb;
	assign cpu_req = cpu.cyc & cpu.stb;

	// ------------------------------
	// grant fsm
	// ------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (dma_req)
					state_d = ARB_DMA; // agnus style priority
				else if (cpu_req)
					state_d = ARB_CPU;
			end
			ARB_DMA: if (ram.ack) state_d = ARB_IDLE;
			ARB_CPU: if (ram.ack) state_d = ARB_IDLE;
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= ARB_IDLE;
		else
			state_q <= state_d;
	end

	// ------------------------------
	// master mux
	// ------------------------------
	assign grant   = (state_q == ARB_DMA) || (state_q == ARB_CPU);
	assign sel_cpu = (state_q == ARB_CPU);

	assign ram.cyc   = grant & (sel_cpu ? cpu.cyc : dma.cyc);
	assign ram.stb   = grant & (sel_cpu ? cpu.stb : dma.stb);
	assign ram.we    = sel_cpu ? cpu.we    : dma.we;
	assign ram.adr   = sel_cpu ? cpu.adr   : dma.adr;
	assign ram.sel   = sel_cpu ? cpu.sel   : dma.sel;
	assign ram.dat_w = sel_cpu ? cpu.dat_w : dma.dat_w;

	// waiting master keeps stb high until its turn
	assign dma.ack   = (state_q == ARB_DMA) & ram.ack;
	assign cpu.ack   = sel_cpu & ram.ack;
	assign dma.dat_r = (state_q == ARB_DMA) ? ram.dat_r : '0;
	assign cpu.dat_r = sel_cpu ? ram.dat_r : '0;

endmodule

// File: hw/chip_ram.sv
// byte-writable chip ram behind a Wishbone slave port, ack one cycle after strobe
`timescale 1ns/1ps

module chip_ram (
	input logic clk,
	wb_if.slave bus
);
	import chipbus_pkg::*;

	localparam int DEPTH = 2 ** $bits(chip_adr_t);

	data_t     mem [DEPTH]; // contents survive reset
	chip_adr_t wadr;
	logic      req;
	logic      ack_q;
	data_t     dat_q;

	assign wadr = bus.adr[$bits(chip_adr_t)-1:0];
	assign req  = bus.cyc & bus.stb & ~ack_q; // first cycle of a transfer

	// handshake, falls again once stb goes away
	always_ff @(posedge clk) begin
		ack_q <= req;
	end

	// array port, write per byte lane
	always_ff @(posedge clk) begin
		if (req && bus.we) begin
			if (bus.sel[1])
				mem[wadr][15:8] <= bus.dat_w[15:8];
			if (bus.sel[0])
				mem[wadr][7:0] <= bus.dat_w[7:0];
		end
		if (req)
			dat_q <= mem[wadr]; // ready together with ack
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_q;

endmodule

// File: hw/custom_regs.sv
// custom register block with the config register, frame counter and latched ntsc mode
`timescale 1ns/1ps

module custom_regs (
	input logic clk,
	input logic reset,       // bus side, from system reset
	input logic ext_reset_i, // power-on only
	input logic sys_reset_i,
	wb_if.slave bus,
	input logic sof_i,
	output logic usr_reset_o,
	output logic ntsc_o
);
	import chipbus_pkg::*;

	reg_idx_t idx;
	logic     req;
	logic     wr_cfg;
	logic     ack_q;
	logic     cfg_ntsc;  // cfg bit 0
	logic     usr_rst_q;
	logic     ntsc_q;
	data_t    frame_q;
	data_t    rd_dat;
	data_t    dat_q;

	assign idx    = bus.adr[$bits(reg_idx_t)-1:0];
	assign req    = bus.cyc & bus.stb & ~ack_q;
	assign wr_cfg = req & bus.we & bus.sel[0] & (idx == REG_CFG);

	// read mux, bit 1 of cfg never stored
	always_comb begin
		case (idx)
			REG_CFG:   rd_dat = data_t'(cfg_ntsc);
			REG_FRAME: rd_dat = frame_q;
			default:   rd_dat = '0;
		endcase
	end

	// ------------------------------
	// handshake and user reset
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q     <= 1'b0;
			usr_rst_q <= 1'b0;
		end else begin
			ack_q     <= req;
			usr_rst_q <= wr_cfg & bus.dat_w[1]; // single cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			dat_q <= rd_dat;
	end

	// config survives user reset
	always_ff @(posedge clk) begin
		if (ext_reset_i)
			cfg_ntsc <= 1'b0;
		else if (wr_cfg)
			cfg_ntsc <= bus.dat_w[0];
	end

	// frame count restarts on every system reset
	always_ff @(posedge clk) begin
		if (sys_reset_i)
			frame_q <= '0;
		else if (sof_i)
			frame_q <= frame_q + 1'b1;
	end

	// video mode only changes under reset
	always_ff @(posedge clk) begin
		if (ext_reset_i)
			ntsc_q <= 1'b0;
		else if (sys_reset_i)
			ntsc_q <= cfg_ntsc;
	end

	assign bus.ack     = ack_q;
	assign bus.dat_r   = dat_q;
	assign usr_reset_o = usr_rst_q;
	assign ntsc_o      = ntsc_q;

endmodule

// File: hw/reset_sequencer.sv
// merges external, keyboard and user reset and holds system reset for a few frames after
`timescale 1ns/1ps
`include "chipbus_params.svh"

module reset_sequencer (
	input logic clk,
	input logic reset,
	input logic kbd_reset_n_i,
	input logic usr_reset_i,
	input logic sof_i,
	output logic sys_reset_o
);

	localparam int CW = $clog2(`RESET_FRAMES + 1);
	localparam logic [CW-1:0] LAST = CW'(`RESET_FRAMES - 1);

	logic          src;       // any source active
	logic [CW-1:0] frame_cnt;
	logic          sys_rst_q;

	assign src = reset | ~kbd_reset_n_i | usr_reset_i;

	always_ff @(posedge clk) begin
		if (src) begin
			sys_rst_q <= 1'b1;
			frame_cnt <= '0;
		end else if (sys_rst_q && sof_i) begin
			if (frame_cnt == LAST)
				sys_rst_q <= 1'b0; // last frame seen, release
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	assign sys_reset_o = sys_rst_q;

endmodule

// File: hw/sample_tick.sv
// makes the 44.1 kHz sample clock enable from the system clock by fractional accumulation
`timescale 1ns/1ps
`include "chipbus_params.svh"

module sample_tick (
	input logic clk,
	input logic reset,
	output logic tick_o
);
	import chipbus_pkg::*;

	localparam acc_t STEP = acc_t'(`SAMPLE_HZ);
	localparam acc_t WRAP = acc_t'(`CLK_HZ);

	acc_t acc_q;
	acc_t acc_next;
	logic tick_q;

	assign acc_next = acc_q + STEP;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_q  <= '0;
			tick_q <= 1'b0;
		end else if (acc_next >= WRAP) begin
			acc_q  <= acc_next - WRAP; // keep the remainder
			tick_q <= 1'b1;
		end else begin
			acc_q  <= acc_next;
			tick_q <= 1'b0;
		end
	end

	assign tick_o = tick_q;

endmodule

// File: hw/minimig_core.sv
// chip bus core with cpu and dma Wishbone ports, chip ram, custom regs and system control
`timescale 1ns/1ps

module minimig_core (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   kbd_reset_n_i,
	input  logic                   sof_i,
	input  chipbus_pkg::rtc_t      rtc_i,
	// cpu port
	input  logic                   cpu_cyc_i,
	input  logic                   cpu_stb_i,
	input  logic                   cpu_we_i,
	input  chipbus_pkg::cpu_adr_t  cpu_adr_i,
	input  chipbus_pkg::bsel_t     cpu_sel_i,
	input  chipbus_pkg::data_t     cpu_dat_i,
	output chipbus_pkg::data_t     cpu_dat_o,
	output logic                   cpu_ack_o,
	// dma port, chip word address
	input  logic                   dma_cyc_i,
	input  logic                   dma_stb_i,
	input  logic                   dma_we_i,
	input  chipbus_pkg::chip_adr_t dma_adr_i,
	input  chipbus_pkg::bsel_t     dma_sel_i,
	input  chipbus_pkg::data_t     dma_dat_i,
	output chipbus_pkg::data_t     dma_dat_o,
	output logic                   dma_ack_o,
	// system control
	output logic                   rst_out_o,
	output logic                   ntsc_o,
	output logic                   sample_tick_o
);
	import chipbus_pkg::*;

	logic sys_reset; // stretched system reset
	logic usr_reset; // from cfg write

	wb_if cpu_bus ();
	wb_if cpu_chip_bus ();
	wb_if dma_bus ();
	wb_if ram_bus ();
	wb_if reg_bus ();

	// ------------------------------
	// external ports onto buses
	// ------------------------------
	assign cpu_bus.cyc   = cpu_cyc_i;
	assign cpu_bus.stb   = cpu_stb_i;
	assign cpu_bus.we    = cpu_we_i;
	assign cpu_bus.adr   = cpu_adr_i;
	assign cpu_bus.sel   = cpu_sel_i;
	assign cpu_bus.dat_w = cpu_dat_i;
	assign cpu_dat_o     = cpu_bus.dat_r;
	assign cpu_ack_o     = cpu_bus.ack;

	assign dma_bus.cyc   = dma_cyc_i;
	assign dma_bus.stb   = dma_stb_i;
	assign dma_bus.we    = dma_we_i;
	assign dma_bus.adr   = cpu_adr_t'(dma_adr_i); // zero above chip bits
	assign dma_bus.sel   = dma_sel_i;
	assign dma_bus.dat_w = dma_dat_i;
	assign dma_dat_o     = dma_bus.dat_r;
	assign dma_ack_o     = dma_bus.ack;

	// ------------------------------
	// bus blocks
	// ------------------------------
	address_decoder i_address_decoder (
		.clk   (clk),
		.reset (sys_reset),
		.cpu   (cpu_bus.slave),
		.chip  (cpu_chip_bus.master),
		.regs  (reg_bus.master),
		.rtc_i (rtc_i)
	);

	chip_arbiter i_chip_arbiter (
		.clk   (clk),
		.reset (sys_reset),
		.dma   (dma_bus.slave),
		.cpu   (cpu_chip_bus.slave),
		.ram   (ram_bus.master)
	);

	chip_ram i_chip_ram (
		.clk (clk),
		.bus (ram_bus.slave)
	);

	custom_regs i_custom_regs (
		.clk         (clk),
		.reset       (sys_reset),
		.ext_reset_i (reset),
		.sys_reset_i (sys_reset),
		.bus         (reg_bus.slave),
		.sof_i       (sof_i),
		.usr_reset_o (usr_reset),
		.ntsc_o      (ntsc_o)
	);

	// ------------------------------
	// system control
	// ------------------------------
	reset_sequencer i_reset_sequencer (
		.clk           (clk),
		.reset         (reset),
		.kbd_reset_n_i (kbd_reset_n_i),
		.usr_reset_i   (usr_reset),
		.sof_i         (sof_i),
		.sys_reset_o   (sys_reset)
	);

	sample_tick i_sample_tick (
		.clk    (clk),
		.reset  (reset),
		.tick_o (sample_tick_o)
	);

	assign rst_out_o = sys_reset;

endmodule

// File: sim/tb_model.svh
// reference model and typed compare tasks for the chip bus testbench, included inside its module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ------------------------------
// reference state
// ------------------------------
data_t ram_model [2 ** `CHIP_AW]; // chip ram image by chip word
logic  cfg_m      = 1'b0;         // ntsc request last written
acc_t  tick_acc_m = '0;           // sample phase
logic  tick_m     = 1'b0;         // expected sample_tick_o this cycle

// byte lanes follow sel
task automatic model_write(input chip_adr_t adr, input bsel_t sel, input data_t dat);
	if (sel[1])
		ram_model[adr][15:8] = dat[15:8];
	if (sel[0])
		ram_model[adr][7:0] = dat[7:0];
endtask

// nibble picked by byte address bits [5:2], zero above
function automatic data_t rtc_nibble(input rtc_t rtc, input cpu_adr_t adr);
	byte_adr_t b;
	b = {adr, 1'b0};
	return data_t'((rtc >> (4 * b[5:2])) & 64'hF);
endfunction

// one clock of the 44.1 kHz phase, rst as seen by the coming edge
task automatic tick_model_step(input logic rst);
	acc_t sum;
	sum = tick_acc_m + `SAMPLE_HZ;
	if (rst) begin
		tick_acc_m = '0;
		tick_m     = 1'b0;
	end else if (sum >= `CLK_HZ) begin
		tick_acc_m = sum - `CLK_HZ; // remainder carries over
		tick_m     = 1'b1;
	end else begin
		tick_acc_m = sum;
		tick_m     = 1'b0;
	end
endtask

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_data(input string name, input data_t exp, input data_t act);
	if (act !== exp) begin
		$display("ERR %s: expected %h actual %h", name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("ERR %s: expected %b actual %b", name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] act);
	if (act !== exp) begin
		$display("ERR %s: expected %0d actual %0d", name, exp, act);
		stop_on_error();
	end
endtask

`endif

// File: sim/tb_minimig_core.sv
// testbench for the chip bus core; random cpu and dma traffic checked against a reference model
`timescale 1ns/1ps
`include "chipbus_params.svh"

module tb_minimig_core;
	import chipbus_pkg::*;

	localparam int N_INIT   = 64;  // window words preloaded over dma
	localparam int N_RAND   = 200; // single cpu cycles
	localparam int N_CONC   = 40;  // rounds of cpu and dma together
	localparam int N_TICKS  = 20;
	localparam int N_TRANS  = N_INIT + N_RAND + 4 * N_CONC + 16;
	localparam int N_FRAMES = 2 * (`RESET_FRAMES + 1) + N_TICKS * (`CLK_HZ / `SAMPLE_HZ) / 64 + 8;
	localparam int WDOG_CYCLES = N_TRANS * 40 + N_FRAMES * 64 * 8;

	localparam cpu_adr_t CFG_ADR   = cpu_adr_t'((`CUSTOM_BASE >> 1) + REG_CFG);
	localparam cpu_adr_t FRAME_ADR = cpu_adr_t'((`CUSTOM_BASE >> 1) + REG_FRAME);
	localparam cpu_adr_t RTC_ADR   = cpu_adr_t'(`RTC_BASE >> 1);
	localparam cpu_adr_t NONE_ADR  = cpu_adr_t'(`CHIP_SPACE_TOP >> 1); // first unmapped word
	localparam int NONE_SPAN = (`RTC_BASE - `CHIP_SPACE_TOP) / 2 - 1;
	localparam int RTC_SPAN  = 2 ** (`RTC_WIN_AW - 1) - 1;

	logic      clk = 1'b0;
	logic      reset = 1'b1;
	logic      kbd_reset_n_i = 1'b1;
	logic      sof_i = 1'b0;
	rtc_t      rtc_i = '0;
	logic      cpu_cyc_i = 1'b0, cpu_stb_i = 1'b0, cpu_we_i = 1'b0;
	cpu_adr_t  cpu_adr_i = '0;
	bsel_t     cpu_sel_i = '0;
	data_t     cpu_dat_i = '0, cpu_dat_o;
	logic      cpu_ack_o;
	logic      dma_cyc_i = 1'b0, dma_stb_i = 1'b0, dma_we_i = 1'b0;
	chip_adr_t dma_adr_i = '0;
	bsel_t     dma_sel_i = '0;
	data_t     dma_dat_i = '0, dma_dat_o;
	logic      dma_ack_o;
	logic      rst_out_o, ntsc_o, sample_tick_o;

	int cyc_cnt    = 0; // clock edges since start
	int frame_seen = 0; // sof pulses since rst_out_o fell
	int ticks_seen = 0;
	int errors     = 0;
	int win_base;       // start of the chip word window under test

	task automatic stop_on_error();
		errors++;
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_model.svh"

	minimig_core i_minimig_core (
		.clk (clk), .reset (reset), .kbd_reset_n_i (kbd_reset_n_i), .sof_i (sof_i), .rtc_i (rtc_i),
		.cpu_cyc_i (cpu_cyc_i), .cpu_stb_i (cpu_stb_i), .cpu_we_i (cpu_we_i),
		.cpu_adr_i (cpu_adr_i), .cpu_sel_i (cpu_sel_i), .cpu_dat_i (cpu_dat_i),
		.cpu_dat_o (cpu_dat_o), .cpu_ack_o (cpu_ack_o),
		.dma_cyc_i (dma_cyc_i), .dma_stb_i (dma_stb_i), .dma_we_i (dma_we_i),
		.dma_adr_i (dma_adr_i), .dma_sel_i (dma_sel_i), .dma_dat_i (dma_dat_i),
		.dma_dat_o (dma_dat_o), .dma_ack_o (dma_ack_o),
		.rst_out_o (rst_out_o), .ntsc_o (ntsc_o), .sample_tick_o (sample_tick_o)
	);

	initial begin
		forever #10 clk = ~clk; // 20 ns period
	end

	// frame pulse every 64 cycles
	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		sof_i   <= (cyc_cnt % 64 == 63);
	end

	// ------------------------------
	// monitors and watchdog
	// ------------------------------
	always @(negedge clk) begin
		if (ticks_seen < N_TICKS) begin
			check_bit("sample tick", tick_m, sample_tick_o);
			if (sample_tick_o)
				ticks_seen++;
			tick_model_step(reset);
		end
		if (rst_out_o)
			frame_seen = 0;
		else if (sof_i)
			frame_seen++;
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("timeout: no end of test after %0d cycles, a bus cycle may be stuck", WDOG_CYCLES);
		stop_on_error();
	end

	// ------------------------------
	// bus cycles
	// ------------------------------
	task automatic cpu_cycle(input logic we, input cpu_adr_t adr, input bsel_t sel,
		input data_t dat, output data_t rd, output int done_at);
		@(posedge clk);
		cpu_cyc_i <= 1'b1;
		cpu_stb_i <= 1'b1;
		cpu_we_i  <= we;
		cpu_adr_i <= adr;
		cpu_sel_i <= sel;
		cpu_dat_i <= dat;
		@(negedge clk);
		while (!cpu_ack_o)
			@(negedge clk);
		rd      = cpu_dat_o; // valid with ack
		done_at = cyc_cnt;
		@(posedge clk);
		cpu_cyc_i <= 1'b0;
		cpu_stb_i <= 1'b0;
	endtask

	task automatic dma_cycle(input logic we, input chip_adr_t adr, input bsel_t sel,
		input data_t dat, output data_t rd, output int done_at);
		@(posedge clk);
		dma_cyc_i <= 1'b1;
		dma_stb_i <= 1'b1;
		dma_we_i  <= we;
		dma_adr_i <= adr;
		dma_sel_i <= sel;
		dma_dat_i <= dat;
		@(negedge clk);
		while (!dma_ack_o)
			@(negedge clk);
		rd      = dma_dat_o;
		done_at = cyc_cnt;
		@(posedge clk);
		dma_cyc_i <= 1'b0;
		dma_stb_i <= 1'b0;
	endtask

	function automatic chip_adr_t window_adr(input int k);
		return chip_adr_t'(win_base + k * 251); // spread out, no repeats in the window
	endfunction

	// random copy of a chip word inside the 2 MB chip space
	function automatic cpu_adr_t cpu_mirror(input chip_adr_t a);
		logic [19-`CHIP_AW:0] mirror;
		mirror = $urandom_range(0, 2 ** (20 - `CHIP_AW) - 1);
		return cpu_adr_t'({mirror, a});
	endfunction

	// rst_out_o high until the edge after the last counted frame
	task automatic stretch_check(input string name);
		int pulses;
		pulses = 0;
		while (pulses < `RESET_FRAMES) begin
			@(negedge clk);
			check_bit(name, 1'b1, rst_out_o);
			if (sof_i)
				pulses++;
		end
		@(negedge clk);
		check_bit(name, 1'b0, rst_out_o);
	endtask

	// read FRAME just after a pulse, well clear of the next one
	task automatic frame_read_check(input string name);
		data_t rd;
		int    t;
		@(negedge clk);
		while (!sof_i)
			@(negedge clk);
		cpu_cycle(1'b0, FRAME_ADR, 2'b11, '0, rd, t);
		check_count(name, 16'(frame_seen), rd);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin : run_tests
		data_t     rd_c, rd_d, dat_c, dat_d;
		chip_adr_t ca, da;
		cpu_adr_t  adr;
		bsel_t     sel_c, sel_d;
		rtc_t      rtc_v;
		logic      we;
		int        kind, t_c, t_d;

		void'($urandom(94393));
		win_base = $urandom_range(0, 2 ** `CHIP_AW - 1);
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		stretch_check("reset stretch");
		check_bit("ntsc after power-up", 1'b0, ntsc_o);

		for (int k = 0; k < N_INIT; k++) begin // full words so reads are defined
			dat_d = data_t'($urandom);
			dma_cycle(1'b1, window_adr(k), 2'b11, dat_d, rd_d, t_d);
			model_write(window_adr(k), 2'b11, dat_d);
		end
		frame_read_check("frame count");

		for (int i = 0; i < N_RAND; i++) begin
			kind  = $urandom_range(0, 9);
			we    = $urandom_range(0, 1);
			sel_c = $urandom_range(1, 3);
			dat_c = data_t'($urandom);
			if (kind < 6) begin
				ca = window_adr($urandom_range(0, N_INIT - 1));
				cpu_cycle(we, cpu_mirror(ca), sel_c, dat_c, rd_c, t_c);
				if (we)
					model_write(ca, sel_c, dat_c);
				else
					check_data("chip read", ram_model[ca], rd_c);
			end else if (kind < 8) begin
				adr = NONE_ADR + $urandom_range(0, NONE_SPAN);
				cpu_cycle(we, adr, sel_c, dat_c, rd_c, t_c);
				if (!we)
					check_data("unmapped read", '0, rd_c);
			end else begin
				rtc_v = {$urandom, $urandom};
				@(posedge clk);
				rtc_i <= rtc_v;
				adr = RTC_ADR + $urandom_range(0, RTC_SPAN);
				cpu_cycle(1'b0, adr, 2'b11, '0, rd_c, t_c);
				check_data("rtc read", rtc_nibble(rtc_v, adr), rd_c);
			end
		end
		frame_read_check("frame count after cpu traffic");

		for (int r = 0; r < N_CONC; r++) begin
			t_d   = $urandom_range(0, N_INIT - 1);
			da    = window_adr(t_d);
			ca    = window_adr((t_d + 1 + $urandom_range(0, N_INIT - 2)) % N_INIT);
			sel_c = $urandom_range(1, 3);
			sel_d = $urandom_range(1, 3);
			dat_c = data_t'($urandom);
			dat_d = data_t'($urandom);
			adr   = cpu_mirror(ca);
			fork
				dma_cycle(1'b1, da, sel_d, dat_d, rd_d, t_d);
				cpu_cycle(1'b1, adr, sel_c, dat_c, rd_c, t_c);
			join
			check_bit("dma ack first on write", 1'b1, t_d < t_c);
			model_write(da, sel_d, dat_d);
			model_write(ca, sel_c, dat_c);
			adr = cpu_mirror(da); // each master reads what the other wrote
			fork
				dma_cycle(1'b0, ca, 2'b11, '0, rd_d, t_d);
				cpu_cycle(1'b0, adr, 2'b11, '0, rd_c, t_c);
			join
			check_bit("dma ack first on read", 1'b1, t_d < t_c);
			check_data("dma reads cpu data", ram_model[ca], rd_d);
			check_data("cpu reads dma data", ram_model[da], rd_c);
		end

		// user reset through cfg, ntsc request latched while held
		cpu_cycle(1'b1, CFG_ADR, 2'b11, 16'h0003, rd_c, t_c);
		cfg_m = 1'b1;
		stretch_check("user reset stretch");
		check_bit("ntsc latch", 1'b1, ntsc_o);
		cpu_cycle(1'b0, FRAME_ADR, 2'b11, '0, rd_c, t_c);
		check_count("frame restart", 16'd0, rd_c);
		cpu_cycle(1'b0, CFG_ADR, 2'b11, '0, rd_c, t_c);
		check_data("cfg readback", data_t'(cfg_m), rd_c);
		frame_read_check("frame count after user reset");

		while (ticks_seen < N_TICKS)
			@(posedge clk);
		if (errors == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_on_error();
		end
	end

endmodule

// File: minimig_core.f
+incdir+common
common/chipbus_pkg.sv
common/wb_if.sv
hw/address_decoder.sv
hw/chip_arbiter.sv
hw/chip_ram.sv
hw/custom_regs.sv
hw/reset_sequencer.sv
hw/sample_tick.sv
hw/minimig_core.sv
+incdir+sim
sim/tb_minimig_core.sv
